// ==== logic/vdec_pkg.sv ====
package vdec_pkg;

  // vector register geometry
  localparam int VLEN  = 128;
  localparam int VLENB = VLEN / 8;

  typedef logic [31:0] word_t;
  // one extra bit over the element index of a full register
  typedef logic [$clog2(VLEN):0] offset_t;
  typedef logic [7:0] vl_t;
  typedef logic [4:0] vreg_t;
  typedef logic [4:0] imm5_t;

  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_t;
  typedef enum logic [1:0] {WIDTH8, WIDTH16, WIDTH32} width_t;

  // operand offset selects from the control unit
  typedef enum logic {VS1_SRC_NORMAL, VS1_SRC_ZERO} vs1_src_t;
  typedef enum logic [2:0] {
    VS2_SRC_NORMAL,
    VS2_SRC_IDX_PLUS_RS1,
    VS2_SRC_IDX_PLUS_UIMM,
    VS2_SRC_IDX_PLUS_1,
    VS2_SRC_RS1,
    VS2_SRC_UIMM,
    VS2_SRC_ZERO
  } vs2_src_t;
  typedef enum logic [2:0] {
    VD_SRC_NORMAL,
    VD_SRC_ZERO,
    VD_SRC_IDX_PLUS_RS1,
    VD_SRC_IDX_PLUS_UIMM,
    VD_SRC_IDX_PLUS_1
  } vd_src_t;

  // decoded instruction
  typedef struct packed {
    vreg_t    vs1;
    vreg_t    vs2;
    vreg_t    vd;
    vs1_src_t vs1_src;
    vs2_src_t vs2_src;
    vd_src_t  vd_src;
    sew_t     sew;
    width_t   eew;
    logic     is_load;
    logic     is_store;
    logic     unit_stride;
    // vm set means unmasked
    logic     vm;
    logic     wen;
    logic     merge_ena;
    logic     sign_extend;
    imm5_t    imm5;
  } vctrl_t;

  typedef struct packed {
    vl_t vl;
    vl_t vstart;
  } vcsr_t;

  typedef struct packed {
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vs3;
    offset_t vs1_offset0;
    offset_t vs1_offset1;
    offset_t vs2_offset0;
    offset_t vs2_offset1;
    offset_t vs3_offset0;
    offset_t vs3_offset1;
    sew_t    sew;
  } rf_req_t;

  typedef struct packed {
    word_t      vs1_data0;
    word_t      vs1_data1;
    word_t      vs2_data0;
    word_t      vs2_data1;
    word_t      vs3_data0;
    word_t      vs3_data1;
    // v0 bits for lane 0 and lane 1
    logic [1:0] mask;
  } rf_data_t;

  typedef struct packed {
    offset_t base;
    logic    active;
    logic    last;
  } elem_pos_t;

  typedef struct packed {
    logic    valid;
    logic    decode_done;
    vreg_t   vd;
    offset_t woffset0;
    offset_t woffset1;
    logic    wen0;
    logic    wen1;
    word_t   vs1_lane0;
    word_t   vs1_lane1;
    word_t   vs2_lane0;
    word_t   vs2_lane1;
    word_t   vs3_lane0;
    word_t   vs3_lane1;
    offset_t vs2_offset0;
    offset_t vs2_offset1;
    word_t   imm;
    word_t   xs1;
    word_t   stride;
    logic    load_ena;
    logic    store_ena;
    sew_t    sew;
    vl_t     vl;
  } de_packet_t;

endpackage

// ==== logic/element_length_calc.sv ====
`timescale 1ns/1ps

module element_length_calc (
  input  vdec_pkg::vctrl_t ctrl,
  input  vdec_pkg::vcsr_t  csr,
  output vdec_pkg::vl_t    eff_vl,
  output vdec_pkg::sew_t   rf_sew
);
  import vdec_pkg::*;

  logic mem_op;
  logic unit_ls;
  sew_t eew_as_sew;

  assign mem_op  = ctrl.is_load | ctrl.is_store;
  assign unit_ls = mem_op & ctrl.unit_stride;

  // vl counts SEW elements, memory side moves EEW elements
  always_comb begin
    eff_vl = csr.vl;
    if (unit_ls) begin
      if (ctrl.sew == SEW32 && ctrl.eew == WIDTH8) begin
        eff_vl = csr.vl >> 2;
      end else if (ctrl.sew == SEW32 && ctrl.eew == WIDTH16) begin
        eff_vl = csr.vl >> 1;
      end else if (ctrl.sew == SEW16 && ctrl.eew == WIDTH8) begin
        eff_vl = csr.vl >> 1;
      end
    end
  end

  always_comb begin
    case (ctrl.eew)
      WIDTH8:  eew_as_sew = SEW8;
      WIDTH16: eew_as_sew = SEW16;
      default: eew_as_sew = SEW32;
    endcase
  end

  assign rf_sew = mem_op ? eew_as_sew : ctrl.sew;

endmodule

// ==== logic/element_sequencer.sv ====
`timescale 1ns/1ps

module element_sequencer (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                v_start,
  input  vdec_pkg::vl_t       vstart,
  input  vdec_pkg::vl_t       eff_vl,
  input  logic                stall_dec,
  input  logic                stall_ex,
  input  logic                flush_dec,
  output vdec_pkg::elem_pos_t pos,
  output logic                v_busy
);
  import vdec_pkg::*;

  offset_t    base;
  logic       busy;
  logic       start;
  logic       advance;
  logic       last;
  logic [8:0] base_plus2;

  // a new instruction is only taken while idle
  assign start   = v_start & ~busy;
  assign advance = busy & ~stall_dec & ~stall_ex;

  // widened so the compare survives a wrap near the top of the range
  assign base_plus2 = {1'b0, base} + 9'd2;
  assign last       = (base_plus2 >= {1'b0, eff_vl}) | (vstart >= eff_vl);

  // busy doubles as the active flag of the current pair
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else if (flush_dec) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (advance && last) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      base <= '0;
    end else if (start) begin
      base <= vstart;
    end else if (advance && !last) begin
      base <= base + offset_t'(2);
    end
  end

  assign pos.base   = base;
  assign pos.active = busy;
  assign pos.last   = last;
  // hazard logic sees busy already in the start cycle
  assign v_busy = busy | v_start;

endmodule

// ==== logic/operand_offset_gen.sv ====
`timescale 1ns/1ps

module operand_offset_gen (
  input  vdec_pkg::vctrl_t     ctrl,
  input  vdec_pkg::elem_pos_t  pos,
  input  vdec_pkg::vl_t        eff_vl,
  input  vdec_pkg::sew_t       rf_sew,
  input  vdec_pkg::word_t      xs1,
  input  vdec_pkg::word_t      xs2,
  input  logic [1:0]           mask_bits,
  output vdec_pkg::rf_req_t    rf_req,
  output vdec_pkg::de_packet_t cand
);
  import vdec_pkg::*;

  offset_t    base1;
  offset_t    rs1_off;
  offset_t    uimm_off;
  offset_t    vs1_off0, vs1_off1;
  offset_t    vs2_off0, vs2_off1;
  offset_t    wr_off0, wr_off1;
  word_t      imm_ext;
  logic       lane_wen0;
  logic       lane_wen1;
  logic [8:0] base1_wide;

  assign base1      = pos.base + offset_t'(1);
  assign base1_wide = {1'b0, pos.base} + 9'd1;
  assign rs1_off    = xs1[$bits(offset_t)-1:0];
  assign uimm_off   = offset_t'(ctrl.imm5);
  assign imm_ext    = ctrl.sign_extend ? {{27{ctrl.imm5[4]}}, ctrl.imm5} : {27'd0, ctrl.imm5};

  assign vs1_off0 = (ctrl.vs1_src == VS1_SRC_ZERO) ? '0 : pos.base;
  assign vs1_off1 = (ctrl.vs1_src == VS1_SRC_ZERO) ? '0 : base1;

  always_comb begin
    case (ctrl.vs2_src)
      VS2_SRC_IDX_PLUS_RS1:  vs2_off0 = pos.base + rs1_off;
      VS2_SRC_IDX_PLUS_UIMM: vs2_off0 = pos.base + uimm_off;
      VS2_SRC_IDX_PLUS_1:    vs2_off0 = base1;
      VS2_SRC_RS1:           vs2_off0 = rs1_off;
      VS2_SRC_UIMM:          vs2_off0 = uimm_off;
      VS2_SRC_ZERO:          vs2_off0 = '0;
      default:               vs2_off0 = pos.base;
    endcase
    // scalar and zero sources repeat the same element in both lanes
    if (ctrl.vs2_src inside {VS2_SRC_RS1, VS2_SRC_UIMM, VS2_SRC_ZERO}) begin
      vs2_off1 = vs2_off0;
    end else begin
      vs2_off1 = vs2_off0 + offset_t'(1);
    end
  end

  always_comb begin
    case (ctrl.vd_src)
      VD_SRC_ZERO:          wr_off0 = '0;
      VD_SRC_IDX_PLUS_RS1:  wr_off0 = pos.base + rs1_off;
      VD_SRC_IDX_PLUS_UIMM: wr_off0 = pos.base + uimm_off;
      VD_SRC_IDX_PLUS_1:    wr_off0 = base1;
      default:              wr_off0 = pos.base;
    endcase
    wr_off1 = (ctrl.vd_src == VD_SRC_ZERO) ? '0 : wr_off0 + offset_t'(1);
  end

  always_comb begin
    if (ctrl.is_store) begin
      lane_wen0 = 1'b0;
      lane_wen1 = 1'b0;
    end else if (ctrl.merge_ena) begin
      lane_wen0 = 1'b1;
      lane_wen1 = 1'b1;
    end else begin
      lane_wen0 = ctrl.wen & (ctrl.vm | mask_bits[0]);
      lane_wen1 = ctrl.wen & (ctrl.vm | mask_bits[1]);
    end
    // odd tail, lane 1 is past the end
    if (base1_wide >= {1'b0, eff_vl}) begin
      lane_wen1 = 1'b0;
    end
    // base only sits at or past vl when vstart did
    if (pos.base >= eff_vl) begin
      lane_wen0 = 1'b0;
      lane_wen1 = 1'b0;
    end
  end

  always_comb begin
    rf_req.vs1         = ctrl.vs1;
    rf_req.vs2         = ctrl.vs2;
    rf_req.vs3         = ctrl.vd;
    rf_req.vs1_offset0 = vs1_off0;
    rf_req.vs1_offset1 = vs1_off1;
    rf_req.vs2_offset0 = vs2_off0;
    rf_req.vs2_offset1 = vs2_off1;
    // vs3 shares the vd field and its offsets
    rf_req.vs3_offset0 = wr_off0;
    rf_req.vs3_offset1 = wr_off1;
    rf_req.sew         = rf_sew;
  end

  // lane data is merged in by the latch
  always_comb begin
    cand             = '0;
    cand.valid       = pos.active;
    cand.decode_done = pos.last;
    cand.vd          = ctrl.vd;
    cand.woffset0    = wr_off0;
    cand.woffset1    = wr_off1;
    cand.wen0        = lane_wen0;
    cand.wen1        = lane_wen1;
    cand.vs2_offset0 = vs2_off0;
    cand.vs2_offset1 = vs2_off1;
    cand.imm         = imm_ext;
    cand.xs1         = xs1;
    cand.stride      = xs2;
    cand.load_ena    = ctrl.is_load;
    cand.store_ena   = ctrl.is_store;
    cand.sew         = ctrl.sew;
    cand.vl          = eff_vl;
  end

endmodule

// ==== logic/decode_execute_latch.sv ====
`timescale 1ns/1ps

module decode_execute_latch (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vdec_pkg::de_packet_t cand,
  input  logic                 active,
  input  vdec_pkg::rf_data_t   rf_rdata,
  input  logic                 stall_dec,
  input  logic                 stall_ex,
  input  logic                 flush_dec,
  output vdec_pkg::de_packet_t de_out
);
  import vdec_pkg::*;

  de_packet_t next_pkt;
  logic       stalled;
  logic       capture;

  assign stalled = stall_dec | stall_ex;
  assign capture = active & ~stalled;

  // candidate plus same-cycle register file data
  always_comb begin
    next_pkt           = cand;
    next_pkt.vs1_lane0 = rf_rdata.vs1_data0;
    next_pkt.vs1_lane1 = rf_rdata.vs1_data1;
    next_pkt.vs2_lane0 = rf_rdata.vs2_data0;
    next_pkt.vs2_lane1 = rf_rdata.vs2_data1;
    next_pkt.vs3_lane0 = rf_rdata.vs3_data0;
    next_pkt.vs3_lane1 = rf_rdata.vs3_data1;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      de_out <= '0;
    end else if (flush_dec) begin
      de_out <= '0;
    end else if (capture) begin
      de_out <= next_pkt;
    end else if (!stalled) begin
      // bubble toward execute
      de_out <= '0;
    end
    // under stall the packet holds
  end

endmodule

// ==== logic/vector_decode_stage.sv ====
`timescale 1ns/1ps

module vector_decode_stage (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   v_start,
  input  vdec_pkg::vctrl_t       ctrl,
  input  vdec_pkg::vcsr_t        csr,
  input  vdec_pkg::word_t        xs1,
  input  vdec_pkg::word_t        xs2,
  input  vdec_pkg::rf_data_t     rf_rdata,
  input  logic                   stall_dec,
  input  logic                   stall_ex,
  input  logic                   flush_dec,
  output logic                   v_busy,
  output vdec_pkg::rf_req_t      rf_req,
  output vdec_pkg::de_packet_t   de_out
);
  import vdec_pkg::*;

  vl_t        eff_vl;
  sew_t       rf_sew;
  elem_pos_t  pos;
  de_packet_t cand;

  element_length_calc u_element_length_calc (
    .ctrl   (ctrl),
    .csr    (csr),
    .eff_vl (eff_vl),
    .rf_sew (rf_sew)
  );

  element_sequencer u_element_sequencer (
    .CLK       (CLK),
    .nRST      (nRST),
    .v_start   (v_start),
    .vstart    (csr.vstart),
    .eff_vl    (eff_vl),
    .stall_dec (stall_dec),
    .stall_ex  (stall_ex),
    .flush_dec (flush_dec),
    .pos       (pos),
    .v_busy    (v_busy)
  );

  // mask bits always come from v0
  operand_offset_gen u_operand_offset_gen (
    .ctrl      (ctrl),
    .pos       (pos),
    .eff_vl    (eff_vl),
    .rf_sew    (rf_sew),
    .xs1       (xs1),
    .xs2       (xs2),
    .mask_bits (rf_rdata.mask),
    .rf_req    (rf_req),
    .cand      (cand)
  );

  decode_execute_latch u_decode_execute_latch (
    .CLK       (CLK),
    .nRST      (nRST),
    .cand      (cand),
    .active    (pos.active),
    .rf_rdata  (rf_rdata),
    .stall_dec (stall_dec),
    .stall_ex  (stall_ex),
    .flush_dec (flush_dec),
    .de_out    (de_out)
  );

endmodule

// ==== verification/tb_vector_decode_stage.sv ====
`timescale 1ns/1ps

module tb_vector_decode_stage;
  import vdec_pkg::*;

  typedef struct packed {
    vctrl_t      ctrl;
    vcsr_t       csr;
    word_t       xs1;
    word_t       xs2;
    logic [63:0] v0;
  } case_t;

  logic       CLK;
  logic       nRST;
  logic       v_start;
  vctrl_t     ctrl;
  vcsr_t      csr;
  word_t      xs1;
  word_t      xs2;
  rf_data_t   rf_rdata;
  logic       stall_dec;
  logic       stall_ex;
  logic       flush_dec;
  logic       v_busy;
  rf_req_t    rf_req;
  de_packet_t de_out;

  case_t       cases[$];
  string       names[$];
  logic [7:0]  cur_base;
  logic [63:0] cur_v0;
  logic [31:0] rng_state;
  int          checks;
  int          value_errors;
  int          other_errors;
  logic        timed_out;

  vector_decode_stage u_vector_decode_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .v_start   (v_start),
    .ctrl      (ctrl),
    .csr       (csr),
    .xs1       (xs1),
    .xs2       (xs2),
    .rf_rdata  (rf_rdata),
    .stall_dec (stall_dec),
    .stall_ex  (stall_ex),
    .flush_dec (flush_dec),
    .v_busy    (v_busy),
    .rf_req    (rf_req),
    .de_out    (de_out)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // register file model, each word is {vreg, offset}
  always_comb begin
    rf_rdata.vs1_data0 = word_t'({rf_req.vs1, rf_req.vs1_offset0});
    rf_rdata.vs1_data1 = word_t'({rf_req.vs1, rf_req.vs1_offset1});
    rf_rdata.vs2_data0 = word_t'({rf_req.vs2, rf_req.vs2_offset0});
    rf_rdata.vs2_data1 = word_t'({rf_req.vs2, rf_req.vs2_offset1});
    rf_rdata.vs3_data0 = word_t'({rf_req.vs3, rf_req.vs3_offset0});
    rf_rdata.vs3_data1 = word_t'({rf_req.vs3, rf_req.vs3_offset1});
    // v0 holds one bit per element
    rf_rdata.mask[0] = cur_v0[cur_base[5:0]];
    rf_rdata.mask[1] = cur_v0[6'(cur_base + 8'd1)];
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vl_t expect_eff_vl(input case_t c);
    vl_t v;
    v = c.csr.vl;
    if ((c.ctrl.is_load || c.ctrl.is_store) && c.ctrl.unit_stride) begin
      case ({c.ctrl.sew, c.ctrl.eew})
        {SEW32, WIDTH8}:  v = c.csr.vl / 4;
        {SEW32, WIDTH16}: v = c.csr.vl / 2;
        {SEW16, WIDTH8}:  v = c.csr.vl / 2;
        default:          v = c.csr.vl;
      endcase
    end
    return v;
  endfunction

  function automatic sew_t expect_rf_sew(input case_t c);
    sew_t s;
    s = c.ctrl.sew;
    if (c.ctrl.is_load || c.ctrl.is_store) begin
      case (c.ctrl.eew)
        WIDTH8:  s = SEW8;
        WIDTH16: s = SEW16;
        default: s = SEW32;
      endcase
    end
    return s;
  endfunction

  function automatic int pair_count(input case_t c);
    int eff;
    eff = int'(expect_eff_vl(c));
    if (int'(c.csr.vstart) >= eff) begin
      return 1;
    end
    return (eff - int'(c.csr.vstart) + 1) / 2;
  endfunction

  function automatic de_packet_t expect_packet(input case_t c, input int j);
    de_packet_t p;
    vl_t        eff;
    offset_t    b;
    offset_t    rs1;
    offset_t    ui;
    offset_t    s1;
    offset_t    s2;
    offset_t    sd;
    logic       m0;
    logic       m1;
    eff = expect_eff_vl(c);
    b   = offset_t'(int'(c.csr.vstart) + 2 * j);
    rs1 = c.xs1[7:0];
    ui  = offset_t'(c.ctrl.imm5);
    s1  = (c.ctrl.vs1_src == VS1_SRC_ZERO) ? '0 : b;
    case (c.ctrl.vs2_src)
      VS2_SRC_NORMAL:        s2 = b;
      VS2_SRC_IDX_PLUS_RS1:  s2 = b + rs1;
      VS2_SRC_IDX_PLUS_UIMM: s2 = b + ui;
      VS2_SRC_IDX_PLUS_1:    s2 = b + 8'd1;
      VS2_SRC_RS1:           s2 = rs1;
      VS2_SRC_UIMM:          s2 = ui;
      default:               s2 = '0;
    endcase
    case (c.ctrl.vd_src)
      VD_SRC_NORMAL:        sd = b;
      VD_SRC_IDX_PLUS_RS1:  sd = b + rs1;
      VD_SRC_IDX_PLUS_UIMM: sd = b + ui;
      VD_SRC_IDX_PLUS_1:    sd = b + 8'd1;
      default:              sd = '0;
    endcase
    p = '0;
    p.valid       = 1'b1;
    p.decode_done = (j == pair_count(c) - 1);
    p.vd          = c.ctrl.vd;
    p.woffset0    = sd;
    p.woffset1    = (c.ctrl.vd_src == VD_SRC_ZERO) ? '0 : sd + 8'd1;
    p.vs2_offset0 = s2;
    // scalar and zero sources name one element for both lanes
    if (c.ctrl.vs2_src inside {VS2_SRC_RS1, VS2_SRC_UIMM, VS2_SRC_ZERO}) begin
      p.vs2_offset1 = s2;
    end else begin
      p.vs2_offset1 = s2 + 8'd1;
    end
    p.vs1_lane0 = word_t'({c.ctrl.vs1, s1});
    p.vs1_lane1 = word_t'({c.ctrl.vs1, (c.ctrl.vs1_src == VS1_SRC_ZERO) ? 8'd0 : s1 + 8'd1});
    p.vs2_lane0 = word_t'({c.ctrl.vs2, p.vs2_offset0});
    p.vs2_lane1 = word_t'({c.ctrl.vs2, p.vs2_offset1});
    p.vs3_lane0 = word_t'({c.ctrl.vd, p.woffset0});
    p.vs3_lane1 = word_t'({c.ctrl.vd, p.woffset1});
    m0 = c.v0[b[5:0]];
    m1 = c.v0[6'(b + 8'd1)];
    if (c.ctrl.is_store) begin
      p.wen0 = 1'b0;
      p.wen1 = 1'b0;
    end else if (c.ctrl.merge_ena) begin
      p.wen0 = 1'b1;
      p.wen1 = 1'b1;
    end else begin
      p.wen0 = c.ctrl.wen & (c.ctrl.vm | m0);
      p.wen1 = c.ctrl.wen & (c.ctrl.vm | m1);
    end
    if (int'(b) + 1 >= int'(eff)) begin
      p.wen1 = 1'b0;
    end
    if (c.csr.vstart >= eff) begin
      p.wen0 = 1'b0;
      p.wen1 = 1'b0;
    end
    p.imm       = c.ctrl.sign_extend ? {{27{c.ctrl.imm5[4]}}, c.ctrl.imm5}
                                     : {27'd0, c.ctrl.imm5};
    p.xs1       = c.xs1;
    p.stride    = c.xs2;
    p.load_ena  = c.ctrl.is_load;
    p.store_ena = c.ctrl.is_store;
    p.sew       = c.ctrl.sew;
    p.vl        = eff;
    return p;
  endfunction

  task automatic compare_value(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      value_errors++;
      $display("ERROR %s.%s expected=%0h actual=%0h", name, field, expected, actual);
    end
  endtask

  task automatic check_packet(input string name, input de_packet_t e, input de_packet_t a);
    compare_value(name, "decode_done", e.decode_done, a.decode_done);
    compare_value(name, "vd", e.vd, a.vd);
    compare_value(name, "woffset0", e.woffset0, a.woffset0);
    compare_value(name, "woffset1", e.woffset1, a.woffset1);
    compare_value(name, "wen0", e.wen0, a.wen0);
    compare_value(name, "wen1", e.wen1, a.wen1);
    compare_value(name, "vs1_lane0", e.vs1_lane0, a.vs1_lane0);
    compare_value(name, "vs1_lane1", e.vs1_lane1, a.vs1_lane1);
    compare_value(name, "vs2_lane0", e.vs2_lane0, a.vs2_lane0);
    compare_value(name, "vs2_lane1", e.vs2_lane1, a.vs2_lane1);
    compare_value(name, "vs3_lane0", e.vs3_lane0, a.vs3_lane0);
    compare_value(name, "vs3_lane1", e.vs3_lane1, a.vs3_lane1);
    compare_value(name, "vs2_offset0", e.vs2_offset0, a.vs2_offset0);
    compare_value(name, "vs2_offset1", e.vs2_offset1, a.vs2_offset1);
    compare_value(name, "imm", e.imm, a.imm);
    compare_value(name, "xs1", e.xs1, a.xs1);
    compare_value(name, "stride", e.stride, a.stride);
    compare_value(name, "load_ena", e.load_ena, a.load_ena);
    compare_value(name, "store_ena", e.store_ena, a.store_ena);
    compare_value(name, "sew", e.sew, a.sew);
    compare_value(name, "vl", e.vl, a.vl);
  endtask

  // roughly a quarter of the cycles see some stall
  task automatic drive_stalls();
    rng_state = xorshift32(rng_state);
    stall_dec = (rng_state[2:0] == 3'd0);
    stall_ex  = (rng_state[5:3] == 3'd0);
  endtask

  task automatic load_cases();
    int          fd;
    int          code;
    string       name;
    string       rest;
    case_t       c;
    logic [31:0] f[22];
    fd = $fopen("verification/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/decode_cases.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        break;
      end
      if (name.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                       f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                       f[21]);
        if (code != 22) begin
          $display("case %s has a malformed line in the case file", name);
          other_errors++;
        end else begin
          c.ctrl.vs1         = vreg_t'(f[0]);
          c.ctrl.vs2         = vreg_t'(f[1]);
          c.ctrl.vd          = vreg_t'(f[2]);
          c.ctrl.vs1_src     = vs1_src_t'(f[3][0]);
          c.ctrl.vs2_src     = vs2_src_t'(f[4][2:0]);
          c.ctrl.vd_src      = vd_src_t'(f[5][2:0]);
          c.ctrl.sew         = sew_t'(f[6][1:0]);
          c.ctrl.eew         = width_t'(f[7][1:0]);
          c.ctrl.is_load     = f[8][0];
          c.ctrl.is_store    = f[9][0];
          c.ctrl.unit_stride = f[10][0];
          c.ctrl.vm          = f[11][0];
          c.ctrl.wen         = f[12][0];
          c.ctrl.merge_ena   = f[13][0];
          c.ctrl.sign_extend = f[14][0];
          c.ctrl.imm5        = imm5_t'(f[15]);
          c.csr.vl           = vl_t'(f[16]);
          c.csr.vstart       = vl_t'(f[17]);
          c.xs1              = f[18];
          c.xs2              = f[19];
          c.v0               = {f[21], f[20]};
          cases.push_back(c);
          names.push_back(name);
        end
      end
    end
    $fclose(fd);
    if (cases.size() < 2) begin
      $display("too few cases were loaded from the case file");
      other_errors++;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (v_busy !== 1'b0 && cycles < 200) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    if (v_busy !== 1'b0) begin
      $display("timeout while waiting for v_busy to drop");
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic start_case(input int idx);
    wait_idle();
    if (timed_out) begin
      return;
    end
    @(posedge CLK);
    #2;
    ctrl     = cases[idx].ctrl;
    csr      = cases[idx].csr;
    xs1      = cases[idx].xs1;
    xs2      = cases[idx].xs2;
    cur_v0   = cases[idx].v0;
    cur_base = cases[idx].csr.vstart;
    v_start  = 1'b1;
    drive_stalls();
    // busy must already show in the strobe cycle
    #1;
    compare_value(names[idx], "v_busy_at_start", 1'b1, v_busy);
  endtask

  // a packet is new only when the edge that loaded it saw no stall
  task automatic collect_packets(input int idx, input int stop_at);
    int n;
    int got;
    int cycles;
    if (timed_out) begin
      return;
    end
    n      = pair_count(cases[idx]);
    got    = 0;
    cycles = 0;
    while (got < stop_at && cycles < 200) begin
      @(posedge CLK);
      #1;
      cycles++;
      if (!stall_dec && !stall_ex && de_out.valid === 1'b1) begin
        check_packet(names[idx], expect_packet(cases[idx], got), de_out);
        compare_value(names[idx], "rf_req.sew", expect_rf_sew(cases[idx]), rf_req.sew);
        got++;
        cur_base = cur_base + 8'd2;
      end
      compare_value(names[idx], "v_busy", got < n, v_busy);
      #1;
      v_start = 1'b0;
      drive_stalls();
    end
    if (got < stop_at) begin
      $display("timeout in case %s after %0d of %0d packets", names[idx], got, stop_at);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case(input int idx);
    start_case(idx);
    collect_packets(idx, pair_count(cases[idx]));
    if (timed_out) begin
      return;
    end
    repeat (3) begin
      @(posedge CLK);
      #1;
      if (!stall_dec && !stall_ex && de_out.valid === 1'b1) begin
        $display("case %s produced a packet after its last one", names[idx]);
        other_errors++;
      end
      #1;
      drive_stalls();
    end
  endtask

  task automatic flush_case(input int idx);
    start_case(idx);
    collect_packets(idx, 1);
    if (timed_out) begin
      return;
    end
    flush_dec = 1'b1;
    @(posedge CLK);
    #1;
    compare_value(names[idx], "valid_after_flush", 1'b0, de_out.valid);
    compare_value(names[idx], "v_busy_after_flush", 1'b0, v_busy);
    #1;
    flush_dec = 1'b0;
    drive_stalls();
  endtask

  initial begin
    nRST         = 1'b0;
    v_start      = 1'b0;
    ctrl         = '0;
    csr          = '0;
    xs1          = '0;
    xs2          = '0;
    stall_dec    = 1'b0;
    stall_ex     = 1'b0;
    flush_dec    = 1'b0;
    cur_base     = '0;
    cur_v0       = '0;
    rng_state    = 32'h27ca;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    load_cases();
    repeat (8) @(posedge CLK);
    #2;
    nRST = 1'b1;
    foreach (cases[i]) begin
      if (!timed_out) begin
        run_case(i);
      end
    end
    // cut the first case short, then the next one must still decode cleanly
    if (!timed_out && cases.size() >= 2) begin
      flush_case(0);
      run_case(1);
    end
    $display("checks=%0d value_errors=%0d other_errors=%0d", checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vector_decode.f ====
logic/vdec_pkg.sv
logic/element_length_calc.sv
logic/element_sequencer.sv
logic/operand_offset_gen.sv
logic/decode_execute_latch.sv
logic/vector_decode_stage.sv
verification/tb_vector_decode_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_vector_decode_stage
FILELIST   := vector_decode.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/decode_cases.txt ====
# name vs1 vs2 vd vs1_src vs2_src vd_src sew eew load store unit vm wen merge sext imm5
# then vl vstart xs1 xs2 v0_lo v0_hi, all hex, enum fields given as their codes
add_basic 01 02 03 0 0 0 2 2 0 0 0 1 1 0 0 00 08 00 00000000 00000000 00000000 00000000
add_odd_tail 04 05 06 0 0 0 1 1 0 0 0 1 1 0 0 00 07 00 00000000 00000000 00000000 00000000
add_vstart 07 08 09 0 0 0 0 0 0 0 0 1 1 0 0 00 0b 03 00000000 00000000 00000000 00000000
vstart_past_vl 0a 0b 0c 0 0 0 2 2 0 0 0 1 1 0 0 00 04 06 00000000 00000000 ffffffff ffffffff
empty_vl 0d 0e 0f 0 0 0 2 2 0 0 0 1 1 0 0 00 00 00 00000000 00000000 ffffffff ffffffff
add_masked 01 02 03 0 0 0 2 2 0 0 0 0 1 0 0 00 0d 00 00000000 00000000 96e1a5c3 0f0f3c3c
store_unit 10 11 12 0 0 0 2 2 0 1 1 1 0 0 0 00 08 00 00000000 00000040 ffffffff ffffffff
merge_masked 13 14 15 0 0 0 1 1 0 0 0 0 0 1 0 00 09 00 00000000 00000000 00000000 00000000
load_32_8 16 17 18 0 0 0 2 0 1 0 1 1 1 0 0 00 10 00 00000000 00000004 00000000 00000000
load_32_16 19 1a 1b 0 0 0 2 1 1 0 1 1 1 0 0 00 0c 00 00000000 00000008 00000000 00000000
store_16_8 1c 1d 1e 0 0 0 1 0 0 1 1 0 0 0 0 00 0a 00 00000000 00000002 a5a5a5a5 00000000
load_8_8 1f 01 02 0 0 0 0 0 1 0 1 0 1 0 0 00 09 00 00000000 00000001 5a5a5a5a 00000000
load_strided 03 04 05 0 0 0 2 0 1 0 0 1 1 0 0 00 08 00 00000000 00000010 00000000 00000000
idx_rs1 06 07 08 0 1 2 2 2 0 0 0 1 1 0 0 00 06 00 00000005 00000000 00000000 00000000
idx_rs1_wrap 18 19 1a 0 1 2 0 0 0 0 0 1 1 0 0 00 06 00 000001fd 00000000 00000000 00000000
idx_uimm 09 0a 0b 0 2 3 1 1 0 0 0 1 1 0 1 13 05 01 00000000 00000000 00000000 00000000
idx_plus1 0c 0d 0e 0 3 4 0 0 0 0 0 1 1 0 0 00 08 02 00000000 00000000 00000000 00000000
scalar_rs1 0f 10 11 1 4 1 2 2 0 0 0 1 1 0 0 00 04 00 0000002a 00000000 00000000 00000000
scalar_uimm 12 13 14 0 5 0 1 1 0 0 0 1 1 0 0 0e 03 00 00000000 00000000 00000000 00000000
zero_no_wen 15 16 17 0 6 0 2 2 0 0 0 0 0 0 1 1f 06 00 00000000 00000000 3c3c3c3c 00000000
